//--- verilog/tlu_cfg_pkg.sv
/*
 * Register map and configuration field types of the TLU controller.
 * Imported by the register block, the config interface and the top level.
 */
package tlu_cfg_pkg;

    typedef logic [15:0] bus_addr_t;   // register bus address
    typedef logic [7:0]  bus_data_t;   // register bus data byte
    typedef logic [1:0]  tlu_mode_t;   // zero keeps RJ45 off

    // register addresses
    localparam bus_addr_t ADDR_CTRL      = 16'd0;   // read version, write soft reset
    localparam bus_addr_t ADDR_CONF1     = 16'd1;
    localparam bus_addr_t ADDR_CONF2     = 16'd2;
    localparam bus_addr_t ADDR_TRIG_NUM0 = 16'd8;   // bytes 8 to 11, LSB first
    localparam bus_addr_t ADDR_LOST      = 16'd12;

    localparam bus_data_t TLU_VERSION = 8'd1;

    // CONF1 fields
    localparam int CONF1_MODE_LSB     = 0;
    localparam int CONF1_MODE_MSB     = 1;
    localparam int CONF1_DISABLE_VETO = 3;

    // CONF2 fields
    localparam int CONF2_ENABLE_RESET = 5;
    localparam int CONF2_INVERT_LEMO  = 6;
    localparam int CONF2_WRITE_TS     = 7;

endpackage

//--- verilog/tlu_data_pkg.sv
/*
 * Trigger data path types and FIFO sizing.
 * Shared by the trigger front end, the FIFO and the top level.
 */
package tlu_data_pkg;

    typedef logic [31:0] trig_word_t;   // word as stored in the FIFO
    typedef logic [31:0] trig_num_t;    // accepted trigger count
    typedef logic [31:0] timestamp_t;   // free-running clock count
    typedef logic [7:0]  lost_cnt_t;    // saturating drop count

    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_ADDR_W = 3;

    // set in every trigger word so the reader can tell it apart
    localparam int TRIG_WORD_FLAG_BIT = 31;

endpackage

//--- verilog/tlu_cfg_if.sv
/*
 * Configuration fields from the register block to the trigger front end.
 * The register block drives the regs side, the front end reads the trigger side.
 */
`timescale 1ns/100ps

interface tlu_cfg_if import tlu_cfg_pkg::*; ();

    tlu_mode_t mode;
    logic      disable_veto;   // ignore EXT_VETO
    logic      enable_reset;   // trigger reset input clears counters
    logic      invert_lemo;
    logic      write_ts;       // timestamp instead of trigger number in words

    modport regs (output mode, disable_veto, enable_reset, invert_lemo, write_ts);

    modport trigger (input mode, disable_veto, enable_reset, invert_lemo, write_ts);

endinterface

//--- verilog/tlu_bus_regs.sv
/*
 * Register bus slave of the TLU controller.
 * Holds CONF1/CONF2, issues the soft reset on a write to address 0 and
 * returns version, config, trigger count and lost count on reads.
 */
`timescale 1ns/100ps

module tlu_bus_regs
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  bus_addr_t bus_add,
    input  bus_data_t bus_data_in,
    input  logic      bus_rd,
    input  logic      bus_wr,
    output bus_data_t bus_data_out,
    output logic      soft_rst,
    tlu_cfg_if.regs   cfg,
    input  trig_num_t trig_num,
    input  lost_cnt_t lost_cnt
);

    bus_data_t conf1;
    bus_data_t conf2;
    trig_num_t trig_num_snap;   // upper bytes of the count read

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            conf1 <= '0;
            conf2 <= '0;
        end
        else if (bus_wr)
        begin
            if (bus_add == ADDR_CONF1)
                conf1 <= bus_data_in;
            if (bus_add == ADDR_CONF2)
                conf2 <= bus_data_in;
        end
    end

    // one cycle pulse, it also clears itself through the merged reset
    always_ff @(posedge clk)
    begin
        if (rst)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus_wr && (bus_add == ADDR_CTRL);
    end

    // reading byte 0 freezes the count so bytes 1..3 belong to the same value
    always_ff @(posedge clk)
    begin
        if (rst)
            trig_num_snap <= '0;
        else if (bus_rd && (bus_add == ADDR_TRIG_NUM0))
            trig_num_snap <= trig_num;
    end

    always_ff @(posedge clk)
    begin
        case (bus_add)
            ADDR_CTRL:          bus_data_out <= TLU_VERSION;
            ADDR_CONF1:         bus_data_out <= conf1;
            ADDR_CONF2:         bus_data_out <= conf2;
            ADDR_TRIG_NUM0:     bus_data_out <= trig_num[7:0];   // live, snapshot taken now
            ADDR_TRIG_NUM0 + 1: bus_data_out <= trig_num_snap[15:8];
            ADDR_TRIG_NUM0 + 2: bus_data_out <= trig_num_snap[23:16];
            ADDR_TRIG_NUM0 + 3: bus_data_out <= trig_num_snap[31:24];
            ADDR_LOST:          bus_data_out <= lost_cnt;
            default:            bus_data_out <= '0;
        endcase
    end

    assign cfg.mode         = conf1[CONF1_MODE_MSB:CONF1_MODE_LSB];
    assign cfg.disable_veto = conf1[CONF1_DISABLE_VETO];
    assign cfg.enable_reset = conf2[CONF2_ENABLE_RESET];
    assign cfg.invert_lemo  = conf2[CONF2_INVERT_LEMO];
    assign cfg.write_ts     = conf2[CONF2_WRITE_TS];

endmodule

//--- verilog/tlu_trigger_input.sv
/*
 * Trigger front end: synchronizes the TLU inputs, picks RJ45 or LEMO,
 * detects trigger and reset edges and writes one word per accepted trigger.
 */
`timescale 1ns/100ps

module tlu_trigger_input
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    tlu_cfg_if.trigger cfg,
    input  logic       rj45_trigger,
    input  logic       lemo_trigger,
    input  logic       rj45_reset,
    input  logic       lemo_reset,
    input  logic       ext_veto,
    output logic       rj45_enabled,
    output timestamp_t timestamp,
    output trig_num_t  trig_num,
    output logic       trig_wr,
    output trig_word_t trig_data
);

    logic       lemo_trig_mod;
    logic [4:0] sync_in;
    logic [4:0] sync_s1, sync_s2, sync_s3;   // three flop chain per input
    logic       trig_sel, reset_sel;
    logic       trig_prev, reset_prev;
    logic       trig_edge, reset_edge;
    logic       veto;
    logic       accept;
    logic       clear_cnt;

    assign lemo_trig_mod = cfg.invert_lemo ? ~lemo_trigger : lemo_trigger;

    // bit order: veto, lemo reset, rj45 reset, lemo trigger, rj45 trigger
    assign sync_in = {ext_veto, lemo_reset, rj45_reset, lemo_trig_mod, rj45_trigger};

    always_ff @(posedge clk)
    begin
        sync_s1 <= sync_in;
        sync_s2 <= sync_s1;
        sync_s3 <= sync_s2;
    end

    // an unplugged RJ45 port reads trigger and reset both high
    always_ff @(posedge clk)
    begin
        if (rst)
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= (cfg.mode != '0) && !(sync_s3[0] && sync_s3[2]);
    end

    assign trig_sel  = rj45_enabled ? sync_s3[0] : sync_s3[1];
    assign reset_sel = rj45_enabled ? sync_s3[2] : sync_s3[3];

    // edge stage
    always_ff @(posedge clk)
    begin
        trig_prev  <= trig_sel;
        reset_prev <= reset_sel;
        if (rst)
        begin
            trig_edge  <= 1'b0;
            reset_edge <= 1'b0;
        end
        else
        begin
            trig_edge  <= trig_sel & ~trig_prev;
            reset_edge <= reset_sel & ~reset_prev & cfg.enable_reset;
        end
    end

    assign veto      = sync_s3[4] && !cfg.disable_veto;
    assign accept    = trig_edge && !veto;
    assign clear_cnt = rst || reset_edge;

    always_ff @(posedge clk)
    begin
        if (clear_cnt)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (clear_cnt)
            trig_num <= '0;
        else if (accept && (trig_num != '1))   // hold at all ones
            trig_num <= trig_num + 1'b1;
    end

    // write register, word carries the number before the increment
    always_ff @(posedge clk)
    begin
        if (rst)
            trig_wr <= 1'b0;
        else
            trig_wr <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            trig_data <= cfg.write_ts ? timestamp : trig_num;
            trig_data[TRIG_WORD_FLAG_BIT] <= 1'b1;
        end
    end

endmodule

//--- verilog/trigger_fifo.sv
/*
 * Show-ahead FIFO for trigger words. The head word sits on rd_data
 * while empty is low; writes into a full buffer are dropped and counted.
 */
`timescale 1ns/100ps

module trigger_fifo
    import tlu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  trig_word_t wr_data,
    input  logic       rd,
    output logic       empty,
    output trig_word_t rd_data,
    output lost_cnt_t  lost_cnt
);

    trig_word_t             mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr, rd_ptr;
    logic [FIFO_ADDR_W:0]   count;   // occupancy, 0..FIFO_DEPTH
    logic                   full;
    logic                   do_wr, do_rd;

    assign full  = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;   // read on empty is ignored

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    assign rd_data = mem[rd_ptr];

    // pointers wrap by overflow, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            lost_cnt <= '0;
        else if (wr && full && (lost_cnt != '1))   // saturates at 255
            lost_cnt <= lost_cnt + 1'b1;
    end

endmodule

//--- verilog/tlu_controller.sv
/*
 * Top level of the single clock TLU controller.
 * Connects register block, trigger front end and trigger FIFO; the
 * external reader pops words through FIFO_READ.
 */
`timescale 1ns/100ps

module tlu_controller
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       RST,
    input  bus_addr_t  BUS_ADD,
    input  bus_data_t  BUS_DATA_IN,
    input  logic       BUS_RD,
    input  logic       BUS_WR,
    output bus_data_t  BUS_DATA_OUT,

    input  logic       RJ45_TRIGGER,
    input  logic       LEMO_TRIGGER,
    input  logic       RJ45_RESET,
    input  logic       LEMO_RESET,
    input  logic       EXT_VETO,
    output logic       RJ45_ENABLED,
    output timestamp_t TIMESTAMP,

    input  logic       FIFO_READ,
    output logic       FIFO_EMPTY,
    output trig_word_t FIFO_DATA
);

    logic       soft_rst;
    logic       core_rst;
    logic       trig_wr;
    trig_word_t trig_data;
    trig_num_t  trig_num;
    lost_cnt_t  lost_cnt;

    assign core_rst = RST | soft_rst;   // bus write to address 0 resets the core

    tlu_cfg_if cfg_if ();

    tlu_bus_regs i_bus_regs (
        .clk          (BUS_CLK),
        .rst          (core_rst),
        .bus_add      (BUS_ADD),
        .bus_data_in  (BUS_DATA_IN),
        .bus_rd       (BUS_RD),
        .bus_wr       (BUS_WR),
        .bus_data_out (BUS_DATA_OUT),
        .soft_rst     (soft_rst),
        .cfg          (cfg_if.regs),
        .trig_num     (trig_num),
        .lost_cnt     (lost_cnt)
    );

    tlu_trigger_input i_trigger_input (
        .clk          (BUS_CLK),
        .rst          (core_rst),
        .cfg          (cfg_if.trigger),
        .rj45_trigger (RJ45_TRIGGER),
        .lemo_trigger (LEMO_TRIGGER),
        .rj45_reset   (RJ45_RESET),
        .lemo_reset   (LEMO_RESET),
        .ext_veto     (EXT_VETO),
        .rj45_enabled (RJ45_ENABLED),
        .timestamp    (TIMESTAMP),
        .trig_num     (trig_num),
        .trig_wr      (trig_wr),
        .trig_data    (trig_data)
    );

    trigger_fifo i_fifo (
        .clk      (BUS_CLK),
        .rst      (core_rst),
        .wr       (trig_wr),
        .wr_data  (trig_data),
        .rd       (FIFO_READ),
        .empty    (FIFO_EMPTY),
        .rd_data  (FIFO_DATA),
        .lost_cnt (lost_cnt)
    );

endmodule

//--- tb/tlu_controller_checker.sv
/*
 * Concurrent assertions on the trigger FIFO and the RJ45 selection.
 * Bound into tlu_controller, nothing instantiates it directly.
 */
`timescale 1ns/100ps

module tlu_controller_checker
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   core_rst,
    input logic                   fifo_empty,
    input logic [FIFO_ADDR_W:0]   fifo_count,
    input logic [FIFO_ADDR_W-1:0] wr_ptr,
    input logic [FIFO_ADDR_W-1:0] rd_ptr,
    input tlu_mode_t              mode,
    input logic                   rj45_enabled
);

    // external or soft reset
    empty_after_reset: assert property (@(posedge clk) core_rst |=> fifo_empty)
        else $error("FIFO_EMPTY low in the cycle after reset");

    // pointers and occupancy are kept apart, so they must agree
    empty_means_no_offset: assert property (@(posedge clk) disable iff (core_rst)
        fifo_empty |-> (wr_ptr == rd_ptr))
        else $error("FIFO flags empty while its pointers differ");

    count_in_range: assert property (@(posedge clk) disable iff (core_rst)
        fifo_count <= FIFO_DEPTH)
        else $error("FIFO occupancy above its depth");

    // enable flag is registered, follows the mode one cycle late
    rj45_off_in_mode_zero: assert property (@(posedge clk) disable iff (rst)
        ($past(mode) == '0) |-> !rj45_enabled)
        else $error("RJ45 enabled while the mode field is zero");

endmodule

bind tlu_controller tlu_controller_checker u_checker (
    .clk          (BUS_CLK),
    .rst          (RST),
    .core_rst     (core_rst),
    .fifo_empty   (FIFO_EMPTY),
    .fifo_count   (i_fifo.count),
    .wr_ptr       (i_fifo.wr_ptr),
    .rd_ptr       (i_fifo.rd_ptr),
    .mode         (cfg_if.mode),
    .rj45_enabled (RJ45_ENABLED)
);

//--- tb/tb_tlu_controller.sv
/*
 * Testbench for the TLU controller. Applies a table of trigger scenarios
 * through the register bus and the trigger inputs, then drains the FIFO.
 */
`timescale 1ns/100ps

module tb_tlu_controller;

    typedef struct {
        logic [7:0] conf1;
        logic [7:0] conf2;
        bit         rj45;     // pulse RJ45 instead of LEMO
        int         pulses;
        bit         veto;
        int         words;    // words expected in the FIFO
        int         lost;
    } row_t;

    localparam int NUM_ROWS = 6;
    localparam int MIN_PULSE_CYCLES = 12;   // shortest pulse period of send_pulses

    logic        BUS_CLK, RST, BUS_RD, BUS_WR;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN, BUS_DATA_OUT;
    logic        RJ45_TRIGGER, LEMO_TRIGGER, RJ45_RESET, LEMO_RESET, EXT_VETO;
    logic        RJ45_ENABLED, FIFO_READ, FIFO_EMPTY;
    logic [31:0] TIMESTAMP, FIFO_DATA;

    row_t        rows [NUM_ROWS];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state = 32'h12e9707a;
    logic [7:0]  rd_byte;

    tlu_controller u_dut (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #20 BUS_CLK = ~BUS_CLK;
    end

    always @(posedge BUS_CLK)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int row_cycles(row_t row);
        return 50 + 19 * row.pulses + 2 * row.words;   // bus traffic, pulses, drain
    endfunction

    task automatic step_cycle();
        @(posedge BUS_CLK);
        #2;   // inputs change just after the edge
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        BUS_ADD = addr;
        BUS_DATA_IN = data;
        BUS_WR = 1'b1;
        step_cycle();
        BUS_WR = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        BUS_ADD = addr;
        BUS_RD = 1'b1;
        step_cycle();   // readback is registered
        BUS_RD = 1'b0;
        data = BUS_DATA_OUT;
    endtask

    // byte 8 snapshots the count, bytes 9 to 11 follow from it
    task automatic read_count(output logic [31:0] value);
        logic [7:0] b;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(16'd8 + 16'(i), b);
            value[8*i +: 8] = b;
        end
    endtask

    task automatic soft_reset();
        bus_write(16'd0, 8'h00);
        repeat (2) step_cycle();
    endtask

    // in RJ45 runs LEMO pulses twice per RJ45 pulse, so a wrong port doubles the count
    task automatic send_pulses(input bit rj45, input int n);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            gap = 4 + int'((next_rand() >> 16) % 8);
            RJ45_TRIGGER = rj45;
            LEMO_TRIGGER = !rj45;
            repeat (2) step_cycle();
            RJ45_TRIGGER = 1'b0;
            LEMO_TRIGGER = rj45;
            repeat (2) step_cycle();
            LEMO_TRIGGER = 1'b0;
            repeat (2) step_cycle();
            LEMO_TRIGGER = rj45;
            repeat (2) step_cycle();
            LEMO_TRIGGER = 1'b0;
            repeat (gap) step_cycle();
        end
    endtask

    task automatic drain_fifo(input bit ts_mode, input int exp_words);
        int          n;
        logic [30:0] prev;
        n = 0;
        prev = '0;
        while (!FIFO_EMPTY && n < 12)
        begin
            check_value("word flag bit", FIFO_DATA[31], 1'b1);
            if (ts_mode)
                check_value("timestamp spacing",
                            (n == 0) || (FIFO_DATA[30:0] >= prev + MIN_PULSE_CYCLES), 1'b1);
            else
                check_value("trigger number", FIFO_DATA[30:0], n);
            prev = FIFO_DATA[30:0];
            FIFO_READ = 1'b1;
            step_cycle();
            FIFO_READ = 1'b0;
            n++;
        end
        check_value("word count", n, exp_words);
    endtask

    task automatic run_row(input row_t row);
        logic [7:0]  b;
        logic [31:0] count;
        int          accepted;
        bus_write(16'd2, 8'h00);   // LEMO back to plain polarity before the mode drops
        repeat (5) step_cycle();
        soft_reset();
        EXT_VETO = row.veto;
        bus_write(16'd1, row.conf1);
        bus_write(16'd2, row.conf2);
        bus_read(16'd1, b);
        check_value("CONF1 readback", b, row.conf1);
        bus_read(16'd2, b);
        check_value("CONF2 readback", b, row.conf2);
        repeat (4) step_cycle();   // through the synchronizers
        if (row.rj45)
            check_value("RJ45_ENABLED", RJ45_ENABLED, 1'b1);
        send_pulses(row.rj45, row.pulses);
        repeat (10) step_cycle();
        accepted = (row.veto && !row.conf1[3]) ? 0 : row.pulses;
        read_count(count);
        check_value("trigger count", count, accepted);
        bus_read(16'd12, b);
        check_value("lost count", b, row.lost);
        drain_fifo(row.conf2[7], row.words);
        EXT_VETO = 1'b0;
    endtask

    task automatic trigger_reset_test();
        logic [31:0] count;
        logic [31:0] ts;
        bus_write(16'd2, 8'h00);   // LEMO back to plain polarity before the mode drops
        repeat (5) step_cycle();
        soft_reset();
        bus_write(16'd2, 8'h20);   // enable_reset
        repeat (4) step_cycle();
        send_pulses(1'b0, 3);
        repeat (10) step_cycle();
        read_count(count);
        check_value("count before trigger reset", count, 3);
        ts = TIMESTAMP;
        repeat (4) step_cycle();
        check_value("timestamp free running", TIMESTAMP, ts + 4);
        LEMO_RESET = 1'b1;
        repeat (2) step_cycle();
        LEMO_RESET = 1'b0;
        repeat (10) step_cycle();
        check_value("timestamp cleared by trigger reset", TIMESTAMP < 12, 1'b1);
        read_count(count);
        check_value("count after trigger reset", count, 0);
        check_value("FIFO_EMPTY before soft reset", FIFO_EMPTY, 1'b0);
        soft_reset();
        check_value("FIFO_EMPTY after soft reset", FIFO_EMPTY, 1'b1);
        read_count(count);
        check_value("count after soft reset", count, 0);
    endtask

    initial
    begin
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        RJ45_TRIGGER = 1'b0;
        LEMO_TRIGGER = 1'b0;
        RJ45_RESET = 1'b0;
        LEMO_RESET = 1'b0;
        EXT_VETO = 1'b0;
        FIFO_READ = 1'b0;

        rows[0] = '{8'h00, 8'h00, 1'b0, 5, 1'b0, 5, 0};    // plain LEMO
        rows[1] = '{8'h00, 8'h00, 1'b0, 3, 1'b1, 0, 0};    // vetoed
        rows[2] = '{8'h08, 8'h00, 1'b0, 3, 1'b1, 3, 0};    // veto disabled
        rows[3] = '{8'h00, 8'h00, 1'b0, 10, 1'b0, 8, 2};   // overflow
        rows[4] = '{8'h01, 8'h40, 1'b1, 4, 1'b0, 4, 0};    // RJ45, LEMO inverted
        rows[5] = '{8'h01, 8'hc0, 1'b1, 6, 1'b0, 6, 0};    // timestamp words

        // extra 150 covers reset, version read and the trigger reset test
        cycle_limit = 150;
        for (int r = 0; r < NUM_ROWS; r++)
            cycle_limit += row_cycles(rows[r]);
        cycle_limit = cycle_limit * 3 / 2;

        repeat (4) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        step_cycle();

        bus_read(16'd0, rd_byte);
        check_value("version", rd_byte, 8'h01);
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(rows[r]);
        trigger_reset_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- all.f
verilog/tlu_cfg_pkg.sv
verilog/tlu_data_pkg.sv
verilog/tlu_cfg_if.sv
verilog/tlu_bus_regs.sv
verilog/tlu_trigger_input.sv
verilog/trigger_fifo.sv
verilog/tlu_controller.sv
tb/tlu_controller_checker.sv
tb/tb_tlu_controller.sv

//--- run.sh
#!/bin/sh
# build the TLU controller testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_tlu_controller -o sim \
    || { echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
